// File: sim.f
logic/bwt_fwd_pkg.sv
logic/fwd_entry_stage.sv
logic/fwd_delay_line.sv
logic/fwd_decide_stage.sv
logic/fwd_update_stage.sv
logic/bwt_fwd_datapath.sv
verif/bwt_fwd_props.sv
verif/tb_bwt_fwd.sv

// File: verif/tb_bwt_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bwt_fwd;

	localparam int NUM_ITEMS = 300;
	localparam int PIPE_LEN = 16;

	logic Clk_32UI, reset_BWT_extend, stall_i;
	logic [63:0] primary_i;
	logic [5:0] status_i;
	logic [7:0] query_i, read_num_i;
	logic [6:0] ptr_curr_i, forward_i_i, min_intv_i;
	logic [63:0] ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i;
	logic occ_valid_o, curr_we_o, ret_valid_o, dram_valid_o;
	logic [63:0] occ_k_o, occ_l_o;
	logic [63:0] ok_x0 [4];
	logic [63:0] ok_x1 [4];
	logic [63:0] ok_x2 [4];
	logic [255:0] curr_data_o;
	logic [6:0] curr_addr_o, ret_o, ptr_curr_o, forward_i_o, min_intv_o;
	logic [7:0] curr_read_num_o, ret_read_num_o, read_num_o;
	logic [5:0] status_o;
	logic [63:0] ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o;
	logic [31:0] addr_k_o, addr_l_o;

	// item table filled before the stream starts
	logic [5:0] it_status [NUM_ITEMS];
	logic [7:0] it_query [NUM_ITEMS];
	logic [6:0] it_ptr [NUM_ITEMS];
	logic [6:0] it_fi [NUM_ITEMS];
	logic [6:0] it_min [NUM_ITEMS];
	logic [63:0] it_x0 [NUM_ITEMS];
	logic [63:0] it_x1 [NUM_ITEMS];
	logic [63:0] it_x2 [NUM_ITEMS];
	logic [63:0] it_info [NUM_ITEMS];
	logic [63:0] it_ok [NUM_ITEMS][4][3];

	int pipe [PIPE_LEN+1]; // tag per model stage where -1 marks a bubble
	int next_tag, retired, emitted, errors, checks;
	logic running, done, prev_adv;
	logic [31:0] seed;

	// predicted decide and update results
	logic [5:0] p_st1, p_status;
	logic [6:0] p_ptr;
	logic p_we, p_ret, p_upd, p_addi, p_issue;
	logic [63:0] p_sel [3];

	bwt_fwd_datapath DUT (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .status_i(status_i), .query_i(query_i),
		.ptr_curr_i(ptr_curr_i), .forward_i_i(forward_i_i), .min_intv_i(min_intv_i),
		.read_num_i(read_num_i), .ik_x0_i(ik_x0_i), .ik_x1_i(ik_x1_i),
		.ik_x2_i(ik_x2_i), .ik_info_i(ik_info_i),
		.occ_valid_o(occ_valid_o), .occ_k_o(occ_k_o), .occ_l_o(occ_l_o),
		.ok0_x0_i(ok_x0[0]), .ok0_x1_i(ok_x1[0]), .ok0_x2_i(ok_x2[0]),
		.ok1_x0_i(ok_x0[1]), .ok1_x1_i(ok_x1[1]), .ok1_x2_i(ok_x2[1]),
		.ok2_x0_i(ok_x0[2]), .ok2_x1_i(ok_x1[2]), .ok2_x2_i(ok_x2[2]),
		.ok3_x0_i(ok_x0[3]), .ok3_x1_i(ok_x1[3]), .ok3_x2_i(ok_x2[3]),
		.curr_we_o(curr_we_o), .curr_data_o(curr_data_o), .curr_addr_o(curr_addr_o),
		.curr_read_num_o(curr_read_num_o), .ret_valid_o(ret_valid_o), .ret_o(ret_o),
		.ret_read_num_o(ret_read_num_o), .status_o(status_o), .ptr_curr_o(ptr_curr_o),
		.forward_i_o(forward_i_o), .min_intv_o(min_intv_o), .read_num_o(read_num_o),
		.ik_x0_o(ik_x0_o), .ik_x1_o(ik_x1_o), .ik_x2_o(ik_x2_o), .ik_info_o(ik_info_o),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o)
	);

	bind bwt_fwd_datapath bwt_fwd_props u_props (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.occ_valid_o(occ_valid_o), .curr_we_o(curr_we_o), .ret_valid_o(ret_valid_o),
		.dram_valid_o(dram_valid_o), .status_o(status_o)
	);

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return {seed[15:0], seed[31:16]}; // low state bits repeat too soon
	endfunction

	function automatic logic [63:0] corr(input logic [63:0] v);
		return (v >= primary_i) ? v - 64'd1 : v; // skip the primary row
	endfunction

	function automatic logic [31:0] blk_addr(input logic [63:0] v);
		return {v[34:7], 4'b0000};
	endfunction

	task automatic compare(input string name, input logic [255:0] got, input logic [255:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// random item of one of eight kinds
	task automatic make_item(input int t);
		int kind;
		int c;
		kind = rand32() % 8;
		c = rand32() % 4;
		it_status[t] = bwt_fwd_pkg::ST_F_RUN;
		it_query[t] = 8'(c);
		it_ptr[t] = 7'(rand32());
		it_fi[t] = 7'(rand32() % 101);
		it_min[t] = 7'(1 + rand32() % 100);
		it_x0[t] = {rand32(), rand32()};
		it_x1[t] = {rand32(), rand32()};
		it_x2[t] = 64'(200 + rand32() % 1000);
		it_info[t] = {rand32(), rand32()};
		for (int j = 0; j < 4; j++) begin
			for (int f = 0; f < 3; f++) begin
				it_ok[t][j][f] = {rand32(), rand32()};
			end
		end
		case (kind)
			0: it_status[t] = bwt_fwd_pkg::ST_F_INIT;
			1: it_ok[t][3-c][2] = 64'(it_min[t]) + 64'(rand32() % 150); // survives
			2: it_ok[t][3-c][2] = 64'(rand32() % it_min[t]); // too small
			3: it_query[t] = 8'(4 + rand32() % 200); // N base
			4: it_ok[t][3-c][2] = it_x2[t];
			5: begin
				it_status[t] = bwt_fwd_pkg::ST_F_BREAK;
				it_fi[t] = 7'd101;
			end
			6: it_status[t] = bwt_fwd_pkg::ST_F_BREAK;
			default: it_fi[t] = 7'(101 + rand32() % 27); // read end reached
		endcase
	endtask

	task automatic predict(input int t);
		int c;
		c = 3 - it_query[t][1:0];
		p_st1 = it_status[t];
		if (p_st1 == bwt_fwd_pkg::ST_F_RUN && it_fi[t] >= 7'd101) begin
			p_st1 = bwt_fwd_pkg::ST_F_BREAK;
		end
		p_status = p_st1;
		p_we = 0;
		p_ret = 0;
		p_upd = 0;
		p_addi = 0;
		p_issue = 0;
		for (int f = 0; f < 3; f++) begin
			p_sel[f] = it_ok[t][c][f];
		end
		if (p_st1 == bwt_fwd_pkg::ST_F_RUN) begin
			if (it_query[t] > 8'd3) begin
				p_we = 1;
				p_status = bwt_fwd_pkg::ST_F_BREAK;
			end else if (p_sel[2] != it_x2[t]) begin
				p_we = 1;
				if (p_sel[2] < 64'(it_min[t])) begin
					p_status = bwt_fwd_pkg::ST_F_BREAK;
				end else begin
					p_upd = 1;
					p_addi = 1;
				end
			end
		end else if (p_st1 == bwt_fwd_pkg::ST_F_BREAK) begin
			p_ret = 1;
			p_we = (it_fi[t] == 7'd101);
			p_status = bwt_fwd_pkg::ST_BCK_INI;
		end else if (p_st1 == bwt_fwd_pkg::ST_F_INIT) begin
			p_status = bwt_fwd_pkg::ST_F_RUN;
		end
		p_issue = (p_status == bwt_fwd_pkg::ST_F_RUN);
		p_ptr = p_we ? it_ptr[t] + 7'd1 : it_ptr[t];
	endtask

	// ------------------------------------------------------------
	task automatic check_outputs();
		int t;
		logic [63:0] nx1, nx2, k;
		t = pipe[1];
		if (t >= 0) begin
			predict(t);
			compare("occ_valid_o", occ_valid_o, p_st1 <= bwt_fwd_pkg::ST_F_RUN);
			k = it_x1[t] - 64'd1;
			if (p_st1 <= bwt_fwd_pkg::ST_F_RUN) begin
				compare("occ_k_o", occ_k_o, corr(k));
				compare("occ_l_o", occ_l_o, corr(k + it_x2[t]));
			end
		end else begin
			compare("occ_valid_o", occ_valid_o, 0);
		end
		t = pipe[14];
		if (t >= 0) begin
			predict(t);
			compare("curr_we_o", curr_we_o, p_we);
			compare("ret_valid_o", ret_valid_o, p_ret);
			if (p_we) begin
				compare("curr_data_o", curr_data_o, {it_info[t], it_x2[t], it_x1[t], it_x0[t]});
				compare("curr_addr_o", curr_addr_o, it_ptr[t]);
				compare("curr_read_num_o", curr_read_num_o, t[7:0]);
			end
			if (p_ret) begin
				compare("ret_o", ret_o, it_info[t][6:0]);
				compare("ret_read_num_o", ret_read_num_o, t[7:0]);
			end
		end else begin
			compare("curr_we_o", curr_we_o, 0);
			compare("ret_valid_o", ret_valid_o, 0);
		end
		if (status_o != bwt_fwd_pkg::ST_BUBBLE) begin
			emitted++;
		end
		t = pipe[16];
		if (t >= 0) begin
			predict(t);
			retired++;
			nx1 = p_upd ? p_sel[1] : it_x1[t];
			nx2 = p_upd ? p_sel[2] : it_x2[t];
			compare("status_o", status_o, p_status);
			compare("ptr_curr_o", ptr_curr_o, p_ptr);
			compare("read_num_o", read_num_o, t[7:0]);
			compare("ik_x0_o", ik_x0_o, p_upd ? p_sel[0] : it_x0[t]);
			compare("ik_x1_o", ik_x1_o, nx1);
			compare("ik_x2_o", ik_x2_o, nx2);
			compare("ik_info_o", ik_info_o, p_upd ? 64'(it_fi[t]) + 64'd1 : it_info[t]);
			compare("forward_i_o", forward_i_o, p_addi ? it_fi[t] + 7'd1 : it_fi[t]);
			compare("min_intv_o", min_intv_o, it_min[t]);
			compare("dram_valid_o", dram_valid_o, p_issue);
			if (p_issue) begin
				compare("addr_k_o", addr_k_o, blk_addr(corr(nx1 - 64'd1)));
				compare("addr_l_o", addr_l_o, blk_addr(corr(nx1 - 64'd1 + nx2)));
			end
		end else begin
			compare("status_o", status_o, bwt_fwd_pkg::ST_BUBBLE);
			compare("dram_valid_o", dram_valid_o, 0);
		end
	endtask

	task automatic drive_slot(input int t);
		if (t < 0) begin
			status_i <= bwt_fwd_pkg::ST_BUBBLE;
		end else begin
			status_i <= it_status[t];
			query_i <= it_query[t];
			ptr_curr_i <= it_ptr[t];
			read_num_i <= t[7:0];
			forward_i_i <= it_fi[t];
			min_intv_i <= it_min[t];
			ik_x0_i <= it_x0[t];
			ik_x1_i <= it_x1[t];
			ik_x2_i <= it_x2[t];
			ik_info_i <= it_info[t];
		end
	endtask

	// ------------------------------------------------------------
	// model pipeline and stimulus take one step per rising edge
	always @(posedge Clk_32UI) begin
		int slot;
		if (prev_adv) begin
			check_outputs();
			if (retired == NUM_ITEMS) begin
				done <= 1'b1;
			end
		end
		prev_adv <= reset_BWT_extend && !stall_i;
		if (reset_BWT_extend && !stall_i) begin
			for (int a = PIPE_LEN; a > 1; a--) begin
				pipe[a] = pipe[a-1];
			end
			pipe[1] = (status_i == bwt_fwd_pkg::ST_BUBBLE) ? -1 : int'(read_num_i) + slot_base();
			slot = -1;
			if (running && next_tag < NUM_ITEMS && rand32() % 4 != 0) begin
				slot = next_tag;
				next_tag++;
			end
			drive_slot(slot);
		end
		for (int j = 0; j < 4; j++) begin // answers for the item about to decide
			ok_x0[j] <= (pipe[13] >= 0) ? it_ok[pipe[13]][j][0] : 64'd0;
			ok_x1[j] <= (pipe[13] >= 0) ? it_ok[pipe[13]][j][1] : 64'd0;
			ok_x2[j] <= (pipe[13] >= 0) ? it_ok[pipe[13]][j][2] : 64'd0;
		end
		stall_i <= running && (rand32() % 4 == 0);
	end

	// tags above 255 share read numbers so the full tag comes from the issue count
	function automatic int slot_base();
		int base;
		base = (next_tag - 1) & ~255;
		if (base + int'(read_num_i) > next_tag - 1) begin
			base -= 256;
		end
		return base;
	endfunction

	initial begin
		Clk_32UI = 1'b0;
		forever #50 Clk_32UI = ~Clk_32UI;
	end

	initial begin
		#(NUM_ITEMS * 20 * 100);
		$display("watchdog expired before all items left the pipeline");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int e0;
		seed = 32'h262a_444d;
		reset_BWT_extend = 1'b0;
		stall_i = 1'b0;
		running = 1'b0;
		done = 1'b0;
		prev_adv = 1'b0;
		next_tag = 0;
		retired = 0;
		emitted = 0;
		errors = 0;
		checks = 0;
		primary_i = {rand32(), rand32()};
		status_i = bwt_fwd_pkg::ST_BUBBLE;
		query_i = '0;
		ptr_curr_i = '0;
		read_num_i = '0;
		forward_i_i = '0;
		min_intv_i = '0;
		ik_x0_i = '0;
		ik_x1_i = '0;
		ik_x2_i = '0;
		ik_info_i = '0;
		for (int j = 0; j < 4; j++) begin
			ok_x0[j] = '0;
			ok_x1[j] = '0;
			ok_x2[j] = '0;
		end
		for (int a = 0; a <= PIPE_LEN; a++) begin
			pipe[a] = -1;
		end
		for (int t = 0; t < NUM_ITEMS; t++) begin
			make_item(t);
		end
		repeat (4) @(posedge Clk_32UI);
		compare("occ_valid_o", occ_valid_o, 0);
		compare("curr_we_o", curr_we_o, 0);
		compare("ret_valid_o", ret_valid_o, 0);
		compare("dram_valid_o", dram_valid_o, 0);
		$display("test reset_values finished, errors %0d", errors);
		reset_BWT_extend <= 1'b1;
		running <= 1'b1;
		e0 = errors;
		wait (done === 1'b1);
		$display("test random_stream finished, errors %0d", errors - e0);
		e0 = errors;
		compare("emitted item count", emitted, NUM_ITEMS);
		$display("test item_count finished, errors %0d", errors - e0);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/bwt_fwd_props.sv
`timescale 1ns/1ps
`default_nettype none

module bwt_fwd_props (
	input wire logic Clk_32UI,
	input wire logic reset_BWT_extend,
	input wire logic stall_i,
	input wire logic occ_valid_o,
	input wire logic curr_we_o,
	input wire logic ret_valid_o,
	input wire logic dram_valid_o,
	input wire logic [bwt_fwd_pkg::STATUS_W-1:0] status_o
);

	// a request is never repeated across a stalled edge
	dram_off_after_stall: assert property (@(posedge Clk_32UI)
		stall_i |=> !dram_valid_o)
		else $error("dram_valid_o high after a stalled edge");

	reset_quiet: assert property (@(posedge Clk_32UI)
		!reset_BWT_extend |=> !(occ_valid_o || curr_we_o || ret_valid_o || dram_valid_o))
		else $error("control output high during reset");

	// ret leaves the decide stage two stages ahead of the item status
	ret_then_bck_ini: assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		(ret_valid_o && !stall_i) ##1 !stall_i |=> status_o == bwt_fwd_pkg::ST_BCK_INI)
		else $error("ret_valid_o not followed by BCK_INI status");

endmodule

`default_nettype wire

// File: logic/bwt_fwd_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module bwt_fwd_datapath (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] primary_i,
	input  logic [bwt_fwd_pkg::STATUS_W-1:0] status_i,
	input  logic [bwt_fwd_pkg::QUERY_W-1:0] query_i,
	input  logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_i, forward_i_i, min_intv_i,
	input  logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	output logic occ_valid_o, // lookup request to the occurrence unit
	output logic [bwt_fwd_pkg::POS_W-1:0] occ_k_o, occ_l_o,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok0_x0_i, ok0_x1_i, ok0_x2_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok1_x0_i, ok1_x1_i, ok1_x2_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok2_x0_i, ok2_x1_i, ok2_x2_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok3_x0_i, ok3_x1_i, ok3_x2_i,
	output logic curr_we_o,
	output logic [bwt_fwd_pkg::CURR_W-1:0] curr_data_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] curr_addr_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] curr_read_num_o,
	output logic ret_valid_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] ret_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] ret_read_num_o,
	output logic [bwt_fwd_pkg::STATUS_W-1:0] status_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_o, forward_i_o, min_intv_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output logic dram_valid_o,
	output logic [bwt_fwd_pkg::ADDR_W-1:0] addr_k_o, addr_l_o
);

	// entry -> delay line
	logic [bwt_fwd_pkg::STATUS_W-1:0] e_status;
	logic [bwt_fwd_pkg::QUERY_W-1:0] e_query;
	logic [bwt_fwd_pkg::QPOS_W-1:0] e_ptr, e_fi, e_min;
	logic [bwt_fwd_pkg::READ_NUM_W-1:0] e_read_num;
	logic [bwt_fwd_pkg::POS_W-1:0] e_x0, e_x1, e_x2, e_info;
	// delay line -> decide
	logic [bwt_fwd_pkg::STATUS_W-1:0] d_status;
	logic [bwt_fwd_pkg::QUERY_W-1:0] d_query;
	logic [bwt_fwd_pkg::QPOS_W-1:0] d_ptr, d_fi, d_min;
	logic [bwt_fwd_pkg::READ_NUM_W-1:0] d_read_num;
	logic [bwt_fwd_pkg::POS_W-1:0] d_x0, d_x1, d_x2, d_info;
	// decide -> update
	logic [bwt_fwd_pkg::STATUS_W-1:0] c_status;
	logic [bwt_fwd_pkg::QPOS_W-1:0] c_ptr, c_fi, c_min;
	logic [bwt_fwd_pkg::READ_NUM_W-1:0] c_read_num;
	logic [bwt_fwd_pkg::POS_W-1:0] c_x0, c_x1, c_x2, c_info;
	logic [bwt_fwd_pkg::POS_W-1:0] c_sel_x0, c_sel_x1, c_sel_x2;
	logic c_update_ik, c_add_i, c_issue_req;

	fwd_entry_stage u_entry (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .status_i(status_i), .query_i(query_i),
		.ptr_curr_i(ptr_curr_i), .read_num_i(read_num_i), .ik_x0_i(ik_x0_i),
		.ik_x1_i(ik_x1_i), .ik_x2_i(ik_x2_i), .ik_info_i(ik_info_i),
		.forward_i_i(forward_i_i), .min_intv_i(min_intv_i),
		.status_o(e_status), .query_o(e_query), .ptr_curr_o(e_ptr), .read_num_o(e_read_num),
		.ik_x0_o(e_x0), .ik_x1_o(e_x1), .ik_x2_o(e_x2), .ik_info_o(e_info),
		.forward_i_o(e_fi), .min_intv_o(e_min),
		.occ_valid_o(occ_valid_o), .occ_k_o(occ_k_o), .occ_l_o(occ_l_o)
	);

	// holds the item while the occurrence unit works
	fwd_delay_line #(.DEPTH(bwt_fwd_pkg::DELAY_DEPTH)) u_delay (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(e_status), .query_i(e_query), .ptr_curr_i(e_ptr), .forward_i_i(e_fi),
		.min_intv_i(e_min), .read_num_i(e_read_num), .ik_x0_i(e_x0), .ik_x1_i(e_x1),
		.ik_x2_i(e_x2), .ik_info_i(e_info),
		.status_o(d_status), .query_o(d_query), .ptr_curr_o(d_ptr), .forward_i_o(d_fi),
		.min_intv_o(d_min), .read_num_o(d_read_num), .ik_x0_o(d_x0), .ik_x1_o(d_x1),
		.ik_x2_o(d_x2), .ik_info_o(d_info)
	);

	fwd_decide_stage u_decide (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(d_status), .query_i(d_query), .ptr_curr_i(d_ptr), .forward_i_i(d_fi),
		.min_intv_i(d_min), .read_num_i(d_read_num), .ik_x0_i(d_x0), .ik_x1_i(d_x1),
		.ik_x2_i(d_x2), .ik_info_i(d_info),
		.ok0_x0_i(ok0_x0_i), .ok0_x1_i(ok0_x1_i), .ok0_x2_i(ok0_x2_i),
		.ok1_x0_i(ok1_x0_i), .ok1_x1_i(ok1_x1_i), .ok1_x2_i(ok1_x2_i),
		.ok2_x0_i(ok2_x0_i), .ok2_x1_i(ok2_x1_i), .ok2_x2_i(ok2_x2_i),
		.ok3_x0_i(ok3_x0_i), .ok3_x1_i(ok3_x1_i), .ok3_x2_i(ok3_x2_i),
		.curr_we_o(curr_we_o), .curr_data_o(curr_data_o), .curr_addr_o(curr_addr_o),
		.curr_read_num_o(curr_read_num_o), .ret_valid_o(ret_valid_o), .ret_o(ret_o),
		.ret_read_num_o(ret_read_num_o),
		.sel_x0_o(c_sel_x0), .sel_x1_o(c_sel_x1), .sel_x2_o(c_sel_x2),
		.update_ik_o(c_update_ik), .add_i_o(c_add_i), .issue_req_o(c_issue_req),
		.status_o(c_status), .ptr_curr_o(c_ptr), .forward_i_o(c_fi), .min_intv_o(c_min),
		.read_num_o(c_read_num), .ik_x0_o(c_x0), .ik_x1_o(c_x1), .ik_x2_o(c_x2),
		.ik_info_o(c_info)
	);

	fwd_update_stage u_update (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .status_i(c_status), .ptr_curr_i(c_ptr),
		.forward_i_i(c_fi), .min_intv_i(c_min), .read_num_i(c_read_num),
		.ik_x0_i(c_x0), .ik_x1_i(c_x1), .ik_x2_i(c_x2), .ik_info_i(c_info),
		.sel_x0_i(c_sel_x0), .sel_x1_i(c_sel_x1), .sel_x2_i(c_sel_x2),
		.update_ik_i(c_update_ik), .add_i_i(c_add_i), .issue_req_i(c_issue_req),
		.status_o(status_o), .ptr_curr_o(ptr_curr_o), .forward_i_o(forward_i_o),
		.min_intv_o(min_intv_o), .read_num_o(read_num_o), .ik_x0_o(ik_x0_o),
		.ik_x1_o(ik_x1_o), .ik_x2_o(ik_x2_o), .ik_info_o(ik_info_o),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o)
	);

endmodule

`default_nettype wire

// File: logic/fwd_update_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_update_stage (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] primary_i,
	input  logic [bwt_fwd_pkg::STATUS_W-1:0] status_i,
	input  logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_i, forward_i_i, min_intv_i,
	input  logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] sel_x0_i, sel_x1_i, sel_x2_i,
	input  logic update_ik_i,
	input  logic add_i_i,
	input  logic issue_req_i,
	output logic [bwt_fwd_pkg::STATUS_W-1:0] status_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_o, forward_i_o, min_intv_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output logic dram_valid_o,
	output logic [bwt_fwd_pkg::ADDR_W-1:0] addr_k_o, addr_l_o
);

	logic [bwt_fwd_pkg::QPOS_W-1:0] i_inc;
	logic [bwt_fwd_pkg::POS_W-1:0] nx0, nx1, nx2, ninfo;
	logic [bwt_fwd_pkg::POS_W-1:0] k_tmp, l_tmp;

	// step 1 registers
	logic [bwt_fwd_pkg::STATUS_W-1:0] s1_status;
	logic s1_issue;
	logic [bwt_fwd_pkg::QPOS_W-1:0] s1_ptr, s1_fi, s1_min;
	logic [bwt_fwd_pkg::READ_NUM_W-1:0] s1_read_num;
	logic [bwt_fwd_pkg::POS_W-1:0] s1_x0, s1_x1, s1_x2, s1_info;
	logic [bwt_fwd_pkg::POS_W-1:0] s1_k, s1_l;

	bwt_fwd_pkg::bwt_pos_u k_pos, l_pos;

	// ------------------------------------------------------------
	// step 1: new interval, next i and uncorrected lookup positions
	always_comb begin
		i_inc = forward_i_i + 1'b1;
		if (update_ik_i) begin
			nx0   = sel_x0_i;
			nx1   = sel_x1_i;
			nx2   = sel_x2_i;
			ninfo = {{(bwt_fwd_pkg::POS_W - bwt_fwd_pkg::QPOS_W){1'b0}}, i_inc};
		end else begin
			nx0   = ik_x0_i;
			nx1   = ik_x1_i;
			nx2   = ik_x2_i;
			ninfo = ik_info_i;
		end
		k_tmp = nx1 - 1'b1;
		l_tmp = k_tmp + nx2;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			s1_status <= bwt_fwd_pkg::ST_BUBBLE;
			s1_issue  <= 1'b0;
		end else if (!stall_i) begin
			s1_status   <= status_i;
			s1_issue    <= issue_req_i;
			s1_ptr      <= ptr_curr_i;
			s1_read_num <= read_num_i;
			s1_fi       <= add_i_i ? i_inc : forward_i_i; // i++
			s1_min      <= min_intv_i;
			s1_x0       <= nx0;
			s1_x1       <= nx1;
			s1_x2       <= nx2;
			s1_info     <= ninfo;
			s1_k        <= k_tmp;
			s1_l        <= l_tmp;
		end
	end

	// ------------------------------------------------------------
	// step 2: primary correction and DRAM block request
	always_comb begin
		k_pos.raw = (s1_k >= primary_i) ? s1_k - 1'b1 : s1_k;
		l_pos.raw = (s1_l >= primary_i) ? s1_l - 1'b1 : s1_l;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o     <= bwt_fwd_pkg::ST_BUBBLE;
			dram_valid_o <= 1'b0;
		end else if (!stall_i) begin
			status_o     <= s1_status;
			dram_valid_o <= s1_issue;
			addr_k_o     <= s1_issue ? {k_pos.blk.block, 4'b0000} : '0;
			addr_l_o     <= s1_issue ? {l_pos.blk.block, 4'b0000} : '0;
			ptr_curr_o   <= s1_ptr;
			read_num_o   <= s1_read_num;
			forward_i_o  <= s1_fi;
			min_intv_o   <= s1_min;
			ik_x0_o      <= s1_x0;
			ik_x1_o      <= s1_x1;
			ik_x2_o      <= s1_x2;
			ik_info_o    <= s1_info;
		end else begin
			dram_valid_o <= 1'b0; // request must not repeat while stalled
			addr_k_o     <= '0;
			addr_l_o     <= '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/fwd_decide_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_decide_stage (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  logic [bwt_fwd_pkg::STATUS_W-1:0] status_i,
	input  logic [bwt_fwd_pkg::QUERY_W-1:0] query_i,
	input  logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_i, forward_i_i, min_intv_i,
	input  logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok0_x0_i, ok0_x1_i, ok0_x2_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok1_x0_i, ok1_x1_i, ok1_x2_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok2_x0_i, ok2_x1_i, ok2_x2_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ok3_x0_i, ok3_x1_i, ok3_x2_i,
	output logic curr_we_o,
	output logic [bwt_fwd_pkg::CURR_W-1:0] curr_data_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] curr_addr_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] curr_read_num_o,
	output logic ret_valid_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] ret_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] ret_read_num_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] sel_x0_o, sel_x1_o, sel_x2_o,
	output logic update_ik_o,
	output logic add_i_o,
	output logic issue_req_o,
	output logic [bwt_fwd_pkg::STATUS_W-1:0] status_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_o, forward_i_o, min_intv_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o
);

	logic is_base;
	logic [bwt_fwd_pkg::POS_W-1:0] sel_x0, sel_x1, sel_x2;

	// ------------------------------------------------------------
	// forward extension uses the complement base, c picks ok[3-c]
	always_comb begin
		is_base = (query_i[bwt_fwd_pkg::QUERY_W-1:2] == '0);
		case (query_i[1:0])
			2'd0: begin
				sel_x0 = ok3_x0_i;
				sel_x1 = ok3_x1_i;
				sel_x2 = ok3_x2_i;
			end
			2'd1: begin
				sel_x0 = ok2_x0_i;
				sel_x1 = ok2_x1_i;
				sel_x2 = ok2_x2_i;
			end
			2'd2: begin
				sel_x0 = ok1_x0_i;
				sel_x1 = ok1_x1_i;
				sel_x2 = ok1_x2_i;
			end
			default: begin
				sel_x0 = ok0_x0_i;
				sel_x1 = ok0_x1_i;
				sel_x2 = ok0_x2_i;
			end
		endcase
	end

	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o    <= bwt_fwd_pkg::ST_BUBBLE;
			curr_we_o   <= 1'b0;
			ret_valid_o <= 1'b0;
			update_ik_o <= 1'b0;
			add_i_o     <= 1'b0;
			issue_req_o <= 1'b0;
		end else if (!stall_i) begin
			curr_we_o   <= 1'b0; // defaults, overridden per status below
			ret_valid_o <= 1'b0;
			update_ik_o <= 1'b0;
			add_i_o     <= 1'b0;
			issue_req_o <= 1'b0;
			status_o    <= status_i;
			ptr_curr_o  <= ptr_curr_i;
			case (status_i)
				bwt_fwd_pkg::ST_F_RUN: begin
					if (!is_base) begin // N base ends the extension
						curr_we_o  <= 1'b1;
						ptr_curr_o <= ptr_curr_i + 1'b1;
						status_o   <= bwt_fwd_pkg::ST_F_BREAK;
					end else if (sel_x2 != ik_x2_i) begin
						curr_we_o  <= 1'b1; // interval shrank, keep the old one
						ptr_curr_o <= ptr_curr_i + 1'b1;
						if (sel_x2 < bwt_fwd_pkg::POS_W'(min_intv_i)) begin
							status_o <= bwt_fwd_pkg::ST_F_BREAK;
						end else begin
							update_ik_o <= 1'b1;
							add_i_o     <= 1'b1;
							issue_req_o <= 1'b1;
						end
					end else begin
						issue_req_o <= 1'b1; // same interval, still running
					end
				end
				bwt_fwd_pkg::ST_F_BREAK: begin
					ret_valid_o <= 1'b1;
					status_o    <= bwt_fwd_pkg::ST_BCK_INI;
					if (forward_i_i == bwt_fwd_pkg::READ_LEN) begin
						curr_we_o  <= 1'b1; // reached read end, save final ik
						ptr_curr_o <= ptr_curr_i + 1'b1;
					end
				end
				bwt_fwd_pkg::ST_F_INIT: begin
					status_o    <= bwt_fwd_pkg::ST_F_RUN;
					issue_req_o <= 1'b1;
				end
				default: begin
				end
			endcase
			curr_data_o     <= {ik_info_i, ik_x2_i, ik_x1_i, ik_x0_i};
			curr_addr_o     <= ptr_curr_i;
			curr_read_num_o <= read_num_i;
			ret_o           <= ik_info_i[bwt_fwd_pkg::QPOS_W-1:0];
			ret_read_num_o  <= read_num_i;
			sel_x0_o        <= sel_x0;
			sel_x1_o        <= sel_x1;
			sel_x2_o        <= sel_x2;
			read_num_o      <= read_num_i;
			ik_x0_o         <= ik_x0_i;
			ik_x1_o         <= ik_x1_i;
			ik_x2_o         <= ik_x2_i;
			ik_info_o       <= ik_info_i;
			forward_i_o     <= forward_i_i;
			min_intv_o      <= min_intv_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/fwd_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_delay_line #(
	parameter int DEPTH = bwt_fwd_pkg::DELAY_DEPTH
) (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  logic [bwt_fwd_pkg::STATUS_W-1:0] status_i,
	input  logic [bwt_fwd_pkg::QUERY_W-1:0] query_i,
	input  logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_i, forward_i_i, min_intv_i,
	input  logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	output logic [bwt_fwd_pkg::STATUS_W-1:0] status_o,
	output logic [bwt_fwd_pkg::QUERY_W-1:0] query_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_o, forward_i_o, min_intv_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o
);

	localparam int PAY_W = bwt_fwd_pkg::QUERY_W + 3 * bwt_fwd_pkg::QPOS_W +
		bwt_fwd_pkg::READ_NUM_W + 4 * bwt_fwd_pkg::POS_W;

	logic [PAY_W-1:0] pay_in;
	logic [bwt_fwd_pkg::STATUS_W-1:0] st_q [DEPTH];
	logic [PAY_W-1:0] pay_q [DEPTH];

	assign pay_in = {query_i, ptr_curr_i, forward_i_i, min_intv_i, read_num_i,
		ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i};

	for (genvar g = 0; g < DEPTH; g++) begin : g_stage
		logic [bwt_fwd_pkg::STATUS_W-1:0] st_d;
		logic [PAY_W-1:0] pay_d;

		if (g == 0) begin : g_head
			assign st_d  = status_i;
			assign pay_d = pay_in;
		end else begin : g_link
			assign st_d  = st_q[g-1];
			assign pay_d = pay_q[g-1];
		end

		always_ff @(posedge Clk_32UI) begin
			if (!reset_BWT_extend) begin
				st_q[g] <= bwt_fwd_pkg::ST_BUBBLE; // slots empty after reset
			end else if (!stall_i) begin
				st_q[g] <= st_d;
			end
		end

		always_ff @(posedge Clk_32UI) begin
			if (!stall_i) begin
				pay_q[g] <= pay_d;
			end
		end
	end

	assign status_o = st_q[DEPTH-1];
	assign {query_o, ptr_curr_o, forward_i_o, min_intv_o, read_num_o,
		ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o} = pay_q[DEPTH-1];

endmodule

`default_nettype wire

// File: logic/fwd_entry_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_entry_stage (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] primary_i,
	input  logic [bwt_fwd_pkg::STATUS_W-1:0] status_i,
	input  logic [bwt_fwd_pkg::QUERY_W-1:0] query_i,
	input  logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_i,
	input  logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_i,
	input  logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  logic [bwt_fwd_pkg::QPOS_W-1:0] forward_i_i,
	input  logic [bwt_fwd_pkg::QPOS_W-1:0] min_intv_i,
	output logic [bwt_fwd_pkg::STATUS_W-1:0] status_o,
	output logic [bwt_fwd_pkg::QUERY_W-1:0] query_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] ptr_curr_o,
	output logic [bwt_fwd_pkg::READ_NUM_W-1:0] read_num_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] forward_i_o,
	output logic [bwt_fwd_pkg::QPOS_W-1:0] min_intv_o,
	output logic occ_valid_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] occ_k_o,
	output logic [bwt_fwd_pkg::POS_W-1:0] occ_l_o
);

	logic [bwt_fwd_pkg::POS_W-1:0] k_tmp;
	logic [bwt_fwd_pkg::POS_W-1:0] l_tmp;
	logic [bwt_fwd_pkg::STATUS_W-1:0] st_next;

	always_comb begin
		k_tmp = ik_x1_i - 1'b1; // interval start minus one
		l_tmp = k_tmp + ik_x2_i; // interval end
		st_next = status_i;
		if (status_i == bwt_fwd_pkg::ST_F_RUN && forward_i_i >= bwt_fwd_pkg::READ_LEN) begin
			st_next = bwt_fwd_pkg::ST_F_BREAK; // whole read consumed
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o    <= bwt_fwd_pkg::ST_BUBBLE;
			occ_valid_o <= 1'b0;
		end else if (!stall_i) begin
			status_o    <= st_next;
			occ_valid_o <= (st_next == bwt_fwd_pkg::ST_F_RUN) ||
				(st_next == bwt_fwd_pkg::ST_F_INIT);
			// the primary row is not stored in the BWT, skip over it
			occ_k_o     <= (k_tmp >= primary_i) ? k_tmp - 1'b1 : k_tmp;
			occ_l_o     <= (l_tmp >= primary_i) ? l_tmp - 1'b1 : l_tmp;
			query_o     <= query_i;
			ptr_curr_o  <= ptr_curr_i;
			read_num_o  <= read_num_i;
			ik_x0_o     <= ik_x0_i;
			ik_x1_o     <= ik_x1_i;
			ik_x2_o     <= ik_x2_i;
			ik_info_o   <= ik_info_i;
			forward_i_o <= forward_i_i;
			min_intv_o  <= min_intv_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/bwt_fwd_pkg.sv
`default_nettype none

package bwt_fwd_pkg;

	// ------------------------------------------------------------
	// item status codes
	localparam int STATUS_W = 6;
	localparam logic [STATUS_W-1:0] ST_F_INIT  = 6'd0; // fresh read, no request sent yet
	localparam logic [STATUS_W-1:0] ST_F_RUN   = 6'd1;
	localparam logic [STATUS_W-1:0] ST_F_BREAK = 6'd2;
	localparam logic [STATUS_W-1:0] ST_BCK_INI = 6'd4; // handed over to backward phase
	localparam logic [STATUS_W-1:0] ST_BUBBLE  = 6'b110000; // empty slot

	// ------------------------------------------------------------
	// field widths
	localparam int QPOS_W     = 7; // forward i, min interval, curr pointer
	localparam logic [QPOS_W-1:0] READ_LEN = 7'd101;
	localparam int READ_NUM_W = 8;
	localparam int POS_W      = 64;
	localparam int QUERY_W    = 8; // codes above 3 are N
	localparam int ADDR_W     = 32;
	localparam int CURR_W     = 4 * POS_W; // info, x2, x1, x0

	localparam int DELAY_DEPTH = 12; // latency of the occurrence unit

	// one BWT position, either as a number or split for DRAM block access
	typedef union packed {
		logic [POS_W-1:0] raw;
		struct packed {
			logic [28:0] hi;
			logic [27:0] block; // 128-entry block index
			logic [6:0]  offset;
		} blk;
	} bwt_pos_u;

endpackage

`default_nettype wire
